/* src.f */
rtl/decode_pkg.sv
rtl/decode_if.sv
rtl/axil_regs.sv
rtl/decode_ctrl.sv
rtl/slot_counter.sv
rtl/insn_decoder.sv
rtl/decode_result_ram.sv
rtl/decode_top.sv
tb/tb_clk_gen.sv
tb/decode_chk.sv
tb/tb_decode_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module tb_decode_top

out=$(./obj_dir/Vtb_decode_top 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

/* tb/tb_decode_top.sv */
// Testbench for the instruction decode stage
// LFSR stimulus, AXI4-Lite write and read tasks, reference decoder model
// Random lines and modes, busy refusal, status polling and stalled responses
`timescale 1ns/1ps

module tb_decode_top;

	localparam int RUNS = 40;
	localparam int CYCLES_PER_RUN = 200;
	localparam int CYCLE_LIMIT = RUNS * CYCLES_PER_RUN;
	localparam int WAIT_LIMIT = 32;
	localparam int POLL_LIMIT = 16;
	localparam int DRIVE_DELAY = 1;

	logic clk;
	logic rst;
	decode_pkg::axil_addr_t awaddr;
	logic awvalid;
	logic awready;
	decode_pkg::word_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	decode_pkg::axil_addr_t araddr;
	logic arvalid;
	logic arready;
	decode_pkg::word_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	int errors = 0;
	int checks = 0;
	int cycles;
	logic [15:0] lfsr;
	// Host view of the line and the mode, and the predicted store contents
	decode_pkg::word_t line_model [decode_pkg::LINE_WORDS];
	logic sup_model;
	decode_pkg::word_t exp_result [decode_pkg::LINE_WORDS];
	decode_pkg::word_t exp_imm [decode_pkg::LINE_WORDS];

	tb_clk_gen i_clk_gen (.clk(clk));

	decode_top i_decode_top (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	// ==================================================
	// Stimulus helpers
	// ==================================================
	// Galois LFSR stepped once for every bit handed out
	function automatic decode_pkg::word_t rand_bits(input int n);
		decode_pkg::word_t v;
		logic out_bit;
		v = '0;
		for (int i = 0; i < n; i++) begin
			out_bit = lfsr[0];
			lfsr = lfsr >> 1;
			if (out_bit) lfsr = lfsr ^ 16'hB400;
			v = {v[30:0], out_bit};
		end
		return v;
	endfunction

	function automatic decode_pkg::axil_addr_t word_addr(input decode_pkg::axil_addr_t base,
			input int idx);
		return base + 7'(idx * 4);
	endfunction

	// Random word with an opcode drawn evenly over the classes and unknown codes
	function automatic decode_pkg::word_t random_insn();
		decode_pkg::word_t w;
		logic [6:0] op;
		logic [2:0] kind;
		w = rand_bits(32);
		kind = 3'(rand_bits(3));
		case (kind)
			3'd0: op = 7'h00;
			3'd1: begin
				op = {3'b000, 4'(rand_bits(4))};
				if (op == 7'h00) op = 7'h0F;
			end
			3'd2: op = 7'h10;
			3'd3: op = 7'h11;
			3'd4: op = 7'h20;
			3'd5: op = 7'h30;
			3'd6: op = 7'h40;
			default: op = 7'(rand_bits(7));
		endcase
		w[6:0] = op;
		return w;
	endfunction

	// ==================================================
	// Reference model
	// ==================================================
	// Packs {known, uses rd, uses rs1, uses rs2, class}
	function automatic logic [6:0] class_info(input logic [6:0] op);
		if (op == 7'h00) return {1'b1, 3'b000, 3'd0};
		if (op >= 7'h01 && op <= 7'h0F) return {1'b1, 3'b111, 3'd1};
		case (op)
			7'h10: return {1'b1, 3'b110, 3'd2};
			7'h11: return {1'b1, 3'b011, 3'd3};
			7'h20: return {1'b1, 3'b011, 3'd4};
			7'h30: return {1'b1, 3'b111, 3'd5};
			7'h40: return {1'b1, 3'b110, 3'd6};
			default: return {1'b0, 3'b000, 3'd0};
		endcase
	endfunction

	// Walks the line in slot order, so earlier slots claim constant words first
	task automatic predict_line();
		logic [7:0] claimed;
		decode_pkg::word_t w;
		decode_pkg::slot_t cur;
		decode_pkg::slot_t pos;
		logic [6:0] info;
		logic priv;
		logic [1:0] cause;
		claimed = '0;
		for (int s = 0; s < decode_pkg::LINE_WORDS; s++) begin
			cur = decode_pkg::slot_t'(s);
			w = line_model[cur];
			pos = w[27:25];
			exp_imm[cur] = '0;
			if (claimed[cur]) begin
				exp_result[cur] = {29'd0, 3'd7};
			end else begin
				info = class_info(w[6:0]);
				priv = (info[5] && w[12:7] >= 6'd56) || (info[4] && w[18:13] >= 6'd56)
					|| (info[3] && w[24:19] >= 6'd56);
				if (!info[6]) cause = 2'd3;
				else if (w[31] && pos <= cur) cause = 2'd2;
				else if (priv && !sup_model) cause = 2'd1;
				else cause = 2'd0;
				exp_result[cur] = {5'd0, pos, w[24:19], w[18:13], w[12:7], w[31], cause,
					info[2:0]};
				if (w[31] && cause == 2'd0) begin
					claimed[pos] = 1'b1;
					exp_imm[cur] = line_model[pos];
				end
			end
		end
	endtask

	// ==================================================
	// Bus tasks and checks
	// ==================================================
	task automatic check_value(input string name, input decode_pkg::word_t expected,
			input decode_pkg::word_t actual);
		checks++;
		assert (actual == expected) else begin
			$display("** Error at %0t ns: %s expected 0x%08h got 0x%08h", $time, name,
				expected, actual);
			errors++;
		end
	endtask

	task automatic axi_write(input decode_pkg::axil_addr_t addr, input decode_pkg::word_t data,
			input logic [3:0] strb, input int stall, output logic [1:0] resp);
		int n;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		while (!awready && n < WAIT_LIMIT) begin
			@(posedge clk);
			#DRIVE_DELAY;
			n++;
		end
		assert (n < WAIT_LIMIT) else begin
			$display("The write address and data were never accepted");
			errors++;
		end
		// Address and data are accepted in the same cycle
		check_value("wready", 32'd1, 32'(wready));
		// The handshake happens on this edge
		@(posedge clk);
		#DRIVE_DELAY;
		awvalid = 1'b0;
		wvalid = 1'b0;
		n = 0;
		while (!bvalid && n < WAIT_LIMIT) begin
			@(posedge clk);
			#DRIVE_DELAY;
			n++;
		end
		assert (n < WAIT_LIMIT) else begin
			$display("No write response arrived");
			errors++;
		end
		repeat (stall) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		resp = bresp;
		bready = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		bready = 1'b0;
	endtask

	task automatic axi_read(input decode_pkg::axil_addr_t addr, input int stall,
			output decode_pkg::word_t data, output logic [1:0] resp);
		int n;
		araddr = addr;
		arvalid = 1'b1;
		n = 0;
		while (!arready && n < WAIT_LIMIT) begin
			@(posedge clk);
			#DRIVE_DELAY;
			n++;
		end
		assert (n < WAIT_LIMIT) else begin
			$display("The read address was never accepted");
			errors++;
		end
		@(posedge clk);
		#DRIVE_DELAY;
		arvalid = 1'b0;
		n = 0;
		while (!rvalid && n < WAIT_LIMIT) begin
			@(posedge clk);
			#DRIVE_DELAY;
			n++;
		end
		assert (n < WAIT_LIMIT) else begin
			$display("No read response arrived");
			errors++;
		end
		repeat (stall) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		rready = 1'b0;
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin : main
		decode_pkg::word_t data;
		logic [1:0] resp;
		decode_pkg::slot_t idx;
		int n;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		lfsr = 16'd23151;
		repeat (5) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		check_value("arready", 32'd1, 32'(arready));
		check_value("bvalid", 32'd0, 32'(bvalid));
		check_value("rvalid", 32'd0, 32'(rvalid));
		axi_read(decode_pkg::ADDR_STATUS, 0, data, resp);
		check_value("rdata (status after reset)", 32'd0, data);
		for (int i = 0; i < decode_pkg::LINE_WORDS; i++) begin
			axi_read(word_addr(decode_pkg::ADDR_RESULT, i), 0, data, resp);
			check_value($sformatf("rdata (result %0d after reset)", i), 32'd0, data);
			axi_read(word_addr(decode_pkg::ADDR_IMM, i), 0, data, resp);
			check_value($sformatf("rdata (constant %0d after reset)", i), 32'd0, data);
		end

		for (int r = 0; r < RUNS; r++) begin
			// New line and mode with random B stalls
			for (int i = 0; i < decode_pkg::LINE_WORDS; i++) begin
				idx = decode_pkg::slot_t'(i);
				line_model[idx] = random_insn();
				axi_write(word_addr(decode_pkg::ADDR_LINE, i), line_model[idx], 4'hF,
					int'(rand_bits(2)), resp);
				check_value("bresp (line write)", 32'(decode_pkg::RESP_OKAY), 32'(resp));
			end
			sup_model = 1'(rand_bits(1));
			axi_write(decode_pkg::ADDR_MODE, {31'd0, sup_model}, 4'h1, int'(rand_bits(2)), resp);
			check_value("bresp (mode write)", 32'(decode_pkg::RESP_OKAY), 32'(resp));
			predict_line();

			// Start a run and hit the busy window without stalls
			axi_write(decode_pkg::ADDR_CTRL, 32'd1, 4'hF, 0, resp);
			check_value("bresp (start write)", 32'(decode_pkg::RESP_OKAY), 32'(resp));
			idx = decode_pkg::slot_t'(rand_bits(3));
			if (r % 2 == 1) begin
				axi_write(word_addr(decode_pkg::ADDR_LINE, int'(idx)), rand_bits(32), 4'hF, 0,
					resp);
				check_value("bresp (line write while busy)", 32'(decode_pkg::RESP_SLVERR),
					32'(resp));
			end else begin
				axi_write(decode_pkg::ADDR_MODE, {31'd0, !sup_model}, 4'h1, 0, resp);
				check_value("bresp (mode write while busy)", 32'(decode_pkg::RESP_SLVERR),
					32'(resp));
			end
			axi_read(decode_pkg::ADDR_STATUS, 0, data, resp);
			check_value("rdata (status during run)", 32'd1, data);

			// Poll with R stalls until done shows up
			n = 0;
			data = 32'd1;
			while (!data[1] && n < POLL_LIMIT) begin
				axi_read(decode_pkg::ADDR_STATUS, int'(rand_bits(2)), data, resp);
				if (data[1]) check_value("rdata (status at end of run)", 32'd2, data);
				else check_value("rdata (status while polling)", 32'd1, data);
				n++;
			end
			assert (n < POLL_LIMIT) else begin
				$display("The decode run never reported done");
				errors++;
			end

			for (int i = 0; i < decode_pkg::LINE_WORDS; i++) begin
				axi_read(word_addr(decode_pkg::ADDR_RESULT, i), int'(rand_bits(2)), data, resp);
				check_value($sformatf("rdata (result %0d)", i),
					exp_result[decode_pkg::slot_t'(i)], data);
				check_value("rresp (result read)", 32'(decode_pkg::RESP_OKAY), 32'(resp));
				axi_read(word_addr(decode_pkg::ADDR_IMM, i), int'(rand_bits(2)), data, resp);
				check_value($sformatf("rdata (constant %0d)", i),
					exp_imm[decode_pkg::slot_t'(i)], data);
			end

			// The refused write must have left the line and the mode alone
			if (r % 2 == 1) begin
				axi_read(word_addr(decode_pkg::ADDR_LINE, int'(idx)), 0, data, resp);
				check_value($sformatf("rdata (line word %0d)", idx), line_model[idx], data);
			end else begin
				axi_read(decode_pkg::ADDR_MODE, 0, data, resp);
				check_value("rdata (mode)", {31'd0, sup_model}, data);
			end
			axi_read(decode_pkg::ADDR_STATUS, 0, data, resp);
			check_value("rdata (status after readback)", 32'd2, data);
			axi_read(word_addr(7'h2C, int'(rand_bits(2))), 0, data, resp);
			check_value("rresp (unmapped read)", 32'(decode_pkg::RESP_SLVERR), 32'(resp));
			check_value("rdata (unmapped read)", 32'd0, data);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog sized for the number of runs
	initial begin : watchdog
		for (cycles = 0; cycles < CYCLE_LIMIT; cycles++) begin
			@(posedge clk);
		end
		$display("The test did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* tb/decode_chk.sv */
// Concurrent checks bound into the decode stage top level
// Response hold rules on the B and R channels of the AXI4-Lite slave
// Run control rules on busy, done and the result store write
`timescale 1ns/1ps

module decode_chk (
	input logic clk,
	input logic rst,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input decode_pkg::word_t rdata,
	input logic busy,
	input logic done,
	input logic we
);

	// A write response may only go away once the master took it
	bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready was seen");

	rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready was seen");

	// Read data must not move under a stalled master
	rdata_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> $stable(rdata))
		else $error("rdata changed while the read response was stalled");

	busy_done_excl: assert property (@(posedge clk) disable iff (rst)
		!(busy && done))
		else $error("busy and done are both high");

	// Busy is high exactly in ST_RUN and ST_FLUSH
	we_in_run: assert property (@(posedge clk) disable iff (rst)
		we |-> busy)
		else $error("result store written outside ST_RUN and ST_FLUSH");

endmodule

bind decode_top decode_chk i_decode_chk (
	.clk(clk),
	.rst(rst),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready),
	.rdata(rdata),
	.busy(busy),
	.done(done),
	.we(result_bus.we)
);

/* tb/tb_clk_gen.sv */
// Clock source for the decode stage testbench
// Free-running clock with a 40 ns period, starting low
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk
);

	localparam int HALF_PERIOD = 20;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule

/* rtl/decode_top.sv */
// Top level of the instruction decode stage
// AXI4-Lite slave ports, register block, FSM, slot counter, decoder and result store
`timescale 1ns/1ps

module decode_top (
	input  logic clk,
	input  logic rst,
	input  decode_pkg::axil_addr_t awaddr,
	input  logic awvalid,
	output logic awready,
	input  decode_pkg::word_t wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  decode_pkg::axil_addr_t araddr,
	input  logic arvalid,
	output logic arready,
	output decode_pkg::word_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready
);

	decode_pkg::word_t [decode_pkg::LINE_WORDS-1:0] line;
	logic supervisor;
	logic start;
	logic busy;
	logic done;
	decode_pkg::slot_t rd_idx;
	decode_pkg::word_t rd_result;
	decode_pkg::word_t rd_imm;

	// Sequencing toward the decoder and results toward the store
	decode_slot_if slot_bus ();
	decode_result_if result_bus ();

	axil_regs i_axil_regs (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.line(line), .supervisor(supervisor), .start(start),
		.busy(busy), .done(done),
		.rd_idx(rd_idx), .rd_result(rd_result), .rd_imm(rd_imm)
	);

	decode_ctrl i_decode_ctrl (
		.clk(clk), .rst(rst), .start(start), .last(slot_bus.last),
		.busy(busy), .done(done), .slot_bus(slot_bus.ctrl)
	);

	slot_counter i_slot_counter (.clk(clk), .rst(rst), .slot_bus(slot_bus.counter));

	insn_decoder i_insn_decoder (
		.clk(clk), .rst(rst), .line(line), .supervisor(supervisor),
		.slot_bus(slot_bus.decoder), .res_bus(result_bus.source)
	);

	decode_result_ram i_decode_result_ram (
		.clk(clk), .rst(rst), .res_bus(result_bus.sink),
		.rd_idx(rd_idx), .rd_result(rd_result), .rd_imm(rd_imm)
	);

endmodule

/* rtl/decode_result_ram.sv */
// Result store of the decode stage
// Eight result words and eight constants, one entry per slot
// Written by the decoder, read combinationally by the host side
`timescale 1ns/1ps

module decode_result_ram (
	input  logic clk,
	input  logic rst,
	decode_result_if.sink res_bus,
	input  decode_pkg::slot_t rd_idx,
	output decode_pkg::word_t rd_result,
	output decode_pkg::word_t rd_imm
);

	decode_pkg::word_t results [decode_pkg::LINE_WORDS];
	decode_pkg::word_t consts [decode_pkg::LINE_WORDS];

	// Both arrays start out zero and take one slot per write
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < decode_pkg::LINE_WORDS; i++) begin
				results[i] <= '0;
				consts[i] <= '0;
			end
		end else if (res_bus.we) begin
			results[res_bus.idx] <= res_bus.result;
			consts[res_bus.idx] <= res_bus.imm;
		end
	end

	// Old entries stay visible until the next run overwrites them
	assign rd_result = results[rd_idx];
	assign rd_imm = consts[rd_idx];

endmodule

/* rtl/insn_decoder.sv */
// Registered decoder for one instruction slot per cycle
// Classifies the opcode, extracts the register fields and the constant
// Tracks which slots of the line are claimed as constants
// Checks for unimplemented opcodes, bad constant positions and privileged registers
`timescale 1ns/1ps

module insn_decoder (
	input logic clk,
	input logic rst,
	input decode_pkg::word_t [decode_pkg::LINE_WORDS-1:0] line,
	input logic supervisor,
	decode_slot_if.decoder slot_bus,
	decode_result_if.source res_bus
);

	decode_pkg::word_t insn;
	logic [6:0] opcode;
	decode_pkg::reg_idx_t rd;
	decode_pkg::reg_idx_t rs1;
	decode_pkg::reg_idx_t rs2;
	decode_pkg::slot_t cpos;
	logic imm_flag;
	decode_pkg::insn_class_t cls;
	logic known;
	logic use_rd;
	logic use_rs1;
	logic use_rs2;
	logic bad_reg;
	decode_pkg::fault_t cause;
	logic take_const;
	logic [decode_pkg::LINE_WORDS-1:0] claimed;
	logic is_claimed;
	decode_pkg::word_t result_next;
	decode_pkg::word_t imm_next;

	// ==================================================
	// Field extraction
	// ==================================================
	assign insn = line[slot_bus.slot];
	assign opcode = insn[6:0];
	assign rd = insn[12:7];
	assign rs1 = insn[18:13];
	assign rs2 = insn[24:19];
	assign cpos = insn[27:25];
	assign imm_flag = insn[31];

	// Opcodes outside the table fall back to the NOP class with no registers
	always_comb begin
		known = 1'b1;
		cls = decode_pkg::CLS_NOP;
		if (opcode == decode_pkg::OP_NOP) begin
			cls = decode_pkg::CLS_NOP;
		end else if (opcode >= decode_pkg::OP_ALU_LO && opcode <= decode_pkg::OP_ALU_HI) begin
			cls = decode_pkg::CLS_ALU;
		end else if (opcode == decode_pkg::OP_LOAD) begin
			cls = decode_pkg::CLS_LOAD;
		end else if (opcode == decode_pkg::OP_STORE) begin
			cls = decode_pkg::CLS_STORE;
		end else if (opcode == decode_pkg::OP_BRANCH) begin
			cls = decode_pkg::CLS_BRANCH;
		end else if (opcode == decode_pkg::OP_FPU) begin
			cls = decode_pkg::CLS_FPU;
		end else if (opcode == decode_pkg::OP_CSR) begin
			cls = decode_pkg::CLS_CSR;
		end else begin
			known = 1'b0;
		end
	end

	// Which register fields the class actually reads or writes
	always_comb begin
		use_rd = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (cls)
			decode_pkg::CLS_ALU, decode_pkg::CLS_FPU: begin
				use_rd = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			decode_pkg::CLS_LOAD, decode_pkg::CLS_CSR: begin
				use_rd = 1'b1;
				use_rs1 = 1'b1;
			end
			decode_pkg::CLS_STORE, decode_pkg::CLS_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			default: ;
		endcase
	end

	// Only used fields count since unused ones may hold anything
	assign bad_reg = !supervisor && (
		(use_rd && rd >= decode_pkg::reg_idx_t'(decode_pkg::PRIV_REG_BASE))
		|| (use_rs1 && rs1 >= decode_pkg::reg_idx_t'(decode_pkg::PRIV_REG_BASE))
		|| (use_rs2 && rs2 >= decode_pkg::reg_idx_t'(decode_pkg::PRIV_REG_BASE)));

	// A constant must sit in a later word of the same line
	always_comb begin
		if (!known) begin
			cause = decode_pkg::FLT_UNIMP;
		end else if (imm_flag && cpos <= slot_bus.slot) begin
			cause = decode_pkg::FLT_BADCONST;
		end else if (bad_reg) begin
			cause = decode_pkg::FLT_BADREG;
		end else begin
			cause = decode_pkg::FLT_NONE;
		end
	end

	// Only a fault-free immediate instruction fetches and claims its constant
	assign take_const = imm_flag && cause == decode_pkg::FLT_NONE;
	assign is_claimed = claimed[slot_bus.slot];

	// ==================================================
	// Result word
	// ==================================================
	always_comb begin
		result_next = '0;
		imm_next = '0;
		if (is_claimed) begin
			// Constant words are data and are not decoded
			result_next[2:0] = decode_pkg::CLS_CONST;
		end else begin
			result_next[2:0] = cls;
			result_next[4:3] = cause;
			result_next[5] = imm_flag;
			result_next[11:6] = rd;
			result_next[17:12] = rs1;
			result_next[23:18] = rs2;
			result_next[26:24] = cpos;
			if (take_const) imm_next = line[cpos];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			claimed <= '0;
			res_bus.we <= 1'b0;
		end else begin
			// Write trails the slot cycle by one
			res_bus.we <= slot_bus.en;
			if (slot_bus.clear) begin
				claimed <= '0;
			end else if (slot_bus.en && !is_claimed && take_const) begin
				claimed[cpos] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (slot_bus.en) begin
			res_bus.idx <= slot_bus.slot;
			res_bus.result <= result_next;
			res_bus.imm <= imm_next;
		end
	end

endmodule

/* rtl/slot_counter.sv */
// Slot index counter for a decode run
// Zeroes on clear, steps once per enabled cycle, flags slot 7
`timescale 1ns/1ps

module slot_counter (
	input logic clk,
	input logic rst,
	decode_slot_if.counter slot_bus
);

	decode_pkg::slot_t slot;

	always_ff @(posedge clk) begin
		if (rst || slot_bus.clear) begin
			slot <= '0;
		end else if (slot_bus.en) begin
			// Wraps back to 0 after slot 7
			slot <= slot + 3'd1;
		end
	end

	assign slot_bus.slot = slot;
	assign slot_bus.last = slot_bus.en
		&& slot == decode_pkg::slot_t'(decode_pkg::LINE_WORDS - 1);

endmodule

/* rtl/decode_ctrl.sv */
// FSM that sequences one decode run over a line
// Idle, eight slot cycles, one flush cycle for the last write, then done
`timescale 1ns/1ps

module decode_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic last,
	output logic busy,
	output logic done,
	decode_slot_if.ctrl slot_bus
);

	decode_pkg::ctrl_state_t state;
	decode_pkg::ctrl_state_t state_next;
	logic launch;

	// A start during a run is dropped
	assign launch = start
		&& (state == decode_pkg::ST_IDLE || state == decode_pkg::ST_DONE);

	always_comb begin
		state_next = state;
		case (state)
			decode_pkg::ST_IDLE,
			decode_pkg::ST_DONE: begin
				if (launch) state_next = decode_pkg::ST_RUN;
			end
			decode_pkg::ST_RUN: begin
				// Slot 7 is the final slot cycle
				if (last) state_next = decode_pkg::ST_FLUSH;
			end
			// The decoder writes slot 7 during this cycle
			decode_pkg::ST_FLUSH: state_next = decode_pkg::ST_DONE;
			default: state_next = decode_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= decode_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign slot_bus.clear = launch;
	assign slot_bus.en = state == decode_pkg::ST_RUN;
	assign busy = state == decode_pkg::ST_RUN || state == decode_pkg::ST_FLUSH;
	// Done holds until the next run starts
	assign done = state == decode_pkg::ST_DONE;

endmodule

/* rtl/axil_regs.sv */
// AXI4-Lite slave of the decode stage
// Line buffer, mode register and the start pulse from the control register
// Write response checks and the readback mux over status and result store
`timescale 1ns/1ps

module axil_regs (
	input  logic clk,
	input  logic rst,
	input  decode_pkg::axil_addr_t awaddr,
	input  logic awvalid,
	output logic awready,
	input  decode_pkg::word_t wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  decode_pkg::axil_addr_t araddr,
	input  logic arvalid,
	output logic arready,
	output decode_pkg::word_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output decode_pkg::word_t [decode_pkg::LINE_WORDS-1:0] line,
	output logic supervisor,
	output logic start,
	input  logic busy,
	input  logic done,
	output decode_pkg::slot_t rd_idx,
	input  decode_pkg::word_t rd_result,
	input  decode_pkg::word_t rd_imm
);

	// Address and data are taken together, so one register drives both readies
	logic wr_accept;
	logic wr_line;
	logic wr_mode;
	logic wr_ctrl;
	logic wr_mapped;
	logic wr_refused;
	decode_pkg::word_t rd_data;
	logic rd_ok;

	assign awready = wr_accept;
	assign wready = wr_accept;

	// ==================================================
	// Write channel
	// ==================================================
	assign wr_line = awaddr[6:5] == decode_pkg::ADDR_LINE[6:5];
	assign wr_mode = awaddr[6:2] == decode_pkg::ADDR_MODE[6:2];
	assign wr_ctrl = awaddr[6:2] == decode_pkg::ADDR_CTRL[6:2];
	// Status, result and constant windows take writes without effect
	assign wr_mapped = wr_line || wr_mode || wr_ctrl
		|| awaddr[6:2] == decode_pkg::ADDR_STATUS[6:2]
		|| awaddr[6:5] == decode_pkg::ADDR_RESULT[6:5]
		|| awaddr[6:5] == decode_pkg::ADDR_IMM[6:5];
	// The line and the mode must not change under a running decode
	assign wr_refused = !wr_mapped || ((wr_line || wr_mode) && busy);

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_accept <= 1'b0;
			bvalid <= 1'b0;
			bresp <= decode_pkg::RESP_OKAY;
			supervisor <= 1'b0;
			start <= 1'b0;
		end else begin
			// Accept only while no response waits and the last accept has ended
			wr_accept <= !wr_accept && awvalid && wvalid && !bvalid;
			// Start lands in the cycle after the handshake
			start <= wr_accept && wr_ctrl && wdata[0];
			if (wr_accept) begin
				bvalid <= 1'b1;
				bresp <= wr_refused ? decode_pkg::RESP_SLVERR : decode_pkg::RESP_OKAY;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (wr_accept && wr_mode && !busy && wstrb[0]) begin
				supervisor <= wdata[0];
			end
		end
	end

	// Line buffer with byte lanes
	always_ff @(posedge clk) begin
		if (wr_accept && wr_line && !busy) begin
			for (int b = 0; b < 4; b++) begin
				if (wstrb[b]) begin
					line[awaddr[4:2]][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

	// ==================================================
	// Read channel
	// ==================================================
	assign arready = !rvalid;
	// The store is read combinationally with the word bits of the address
	assign rd_idx = araddr[4:2];

	always_comb begin
		rd_data = '0;
		rd_ok = 1'b1;
		if (araddr[6:5] == decode_pkg::ADDR_LINE[6:5]) begin
			rd_data = line[araddr[4:2]];
		end else if (araddr[6:2] == decode_pkg::ADDR_MODE[6:2]) begin
			rd_data = {31'd0, supervisor};
		end else if (araddr[6:2] == decode_pkg::ADDR_CTRL[6:2]) begin
			// Start is a pulse with nothing to read back
			rd_data = '0;
		end else if (araddr[6:2] == decode_pkg::ADDR_STATUS[6:2]) begin
			rd_data = {30'd0, done, busy};
		end else if (araddr[6:5] == decode_pkg::ADDR_RESULT[6:5]) begin
			rd_data = rd_result;
		end else if (araddr[6:5] == decode_pkg::ADDR_IMM[6:5]) begin
			rd_data = rd_imm;
		end else begin
			rd_ok = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (arvalid && arready) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// Data and response are held with rvalid until the master takes them
	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			rdata <= rd_data;
			rresp <= rd_ok ? decode_pkg::RESP_OKAY : decode_pkg::RESP_SLVERR;
		end
	end

endmodule

/* rtl/decode_if.sv */
// Slot interface between the controller, the slot counter and the decoder
// Result interface between the decoder and the result store
`timescale 1ns/1ps

// Sequencing signals for one decode run
interface decode_slot_if;
	// One-cycle pulse at the start of a run
	logic clear;
	// High for the eight slot cycles of a run
	logic en;
	decode_pkg::slot_t slot;
	// Marks the cycle of slot 7
	logic last;

	modport ctrl (output clear, output en);
	modport counter (input clear, input en, output slot, output last);
	modport decoder (input clear, input en, input slot);
endinterface

// One decoded slot on its way into the result store
interface decode_result_if;
	logic we;
	decode_pkg::slot_t idx;
	decode_pkg::word_t result;
	decode_pkg::word_t imm;

	modport source (output we, output idx, output result, output imm);
	modport sink (input we, input idx, input result, input imm);
endinterface

/* rtl/decode_pkg.sv */
// Shared definitions for the instruction decode stage
// Vector types for words, slots, register numbers and bus addresses
// Class, fault and controller state encodings
// Opcode table, bus responses and the host register map
package decode_pkg;

	// ==================================================
	// Widths that carry a meaning
	// ==================================================
	typedef logic [31:0] word_t;
	typedef logic [2:0] slot_t;
	typedef logic [5:0] reg_idx_t;
	typedef logic [6:0] axil_addr_t;

	localparam int LINE_WORDS = 8;
	// Registers from this number up are reserved for supervisor mode
	localparam int PRIV_REG_BASE = 56;

	// Instruction class as reported in bits 2..0 of a result word
	typedef enum logic [2:0] {
		CLS_NOP    = 3'd0,
		CLS_ALU    = 3'd1,
		CLS_LOAD   = 3'd2,
		CLS_STORE  = 3'd3,
		CLS_BRANCH = 3'd4,
		CLS_FPU    = 3'd5,
		CLS_CSR    = 3'd6,
		CLS_CONST  = 3'd7
	} insn_class_t;

	// Numeric order follows priority so UNIMP wins over the rest
	typedef enum logic [1:0] {
		FLT_NONE     = 2'd0,
		FLT_BADREG   = 2'd1,
		FLT_BADCONST = 2'd2,
		FLT_UNIMP    = 2'd3
	} fault_t;

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_RUN   = 2'd1,
		ST_FLUSH = 2'd2,
		ST_DONE  = 2'd3
	} ctrl_state_t;

	// ==================================================
	// Opcode table
	// ==================================================
	localparam logic [6:0] OP_NOP    = 7'h00;
	localparam logic [6:0] OP_ALU_LO = 7'h01;
	localparam logic [6:0] OP_ALU_HI = 7'h0F;
	localparam logic [6:0] OP_LOAD   = 7'h10;
	localparam logic [6:0] OP_STORE  = 7'h11;
	localparam logic [6:0] OP_BRANCH = 7'h20;
	localparam logic [6:0] OP_FPU    = 7'h30;
	localparam logic [6:0] OP_CSR    = 7'h40;

	// AXI4-Lite response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Register map with eight-word line, result and constant windows
	localparam axil_addr_t ADDR_LINE   = 7'h00;
	localparam axil_addr_t ADDR_MODE   = 7'h20;
	localparam axil_addr_t ADDR_CTRL   = 7'h24;
	localparam axil_addr_t ADDR_STATUS = 7'h28;
	localparam axil_addr_t ADDR_RESULT = 7'h40;
	localparam axil_addr_t ADDR_IMM    = 7'h60;

endpackage
